// ==== sources.f ====
+incdir+source
+incdir+testbench
source/aimbot_pkg.sv
source/cam_byte_packer.sv
source/pixel_fifo.sv
source/pixel_combine.sv
source/video_out.sv
source/line_tick.sv
source/aimbot_top.sv
testbench/aimbot_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -Wno-fatal --top-module aimbot_tb \
    -f sources.f -Mdir build/obj -o aimbot_sim > build/compile.log 2>&1 \
    || { cat build/compile.log; echo "compile failed"; exit 1; }

# a crash or assertion stop counts as a failed run.
./build/obj/aimbot_sim > build/sim.log 2>&1 \
    || echo "Test FAILED" >> build/sim.log

cat build/sim.log

grep -q "Test FAILED" build/sim.log \
    && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== testbench/aimbot_cases.svh ====
`ifndef AIMBOT_CASES_SVH
`define AIMBOT_CASES_SVH

    // ----------------------------------------
    // case table
    // ----------------------------------------

    typedef struct packed {
        view_sel_t  view;
        logic [7:0] frames;      // frame repeats with the same pixels.
        logic [7:0] ready_mask;  // vid_ready pattern indexed by cyc % 8.
        logic       misalign;    // camera 2 gets a stray pixel ahead of its frame.
        logic       exp_ovf;
        logic       exp_err;
    } case_t;

    localparam int NUM_CASES = 6;

    case_t cases [NUM_CASES] = '{
        '{VIEW_CAM1, 8'd2, 8'hff, 1'b0, 1'b0, 1'b0},
        '{VIEW_CAM2, 8'd2, 8'hff, 1'b0, 1'b0, 1'b0},
        '{VIEW_AVG,  8'd2, 8'hff, 1'b0, 1'b0, 1'b0},
        '{VIEW_AVG,  8'd2, 8'hdb, 1'b0, 1'b0, 1'b0},
        '{VIEW_CAM1, 8'd2, 8'h00, 1'b0, 1'b1, 1'b0},
        '{VIEW_CAM1, 8'd1, 8'hff, 1'b1, 1'b0, 1'b1}
    };

    logic [15:0] cam1_pix [FRAME_PIX];
    logic [15:0] cam2_pix [FRAME_PIX];

    // ----------------------------------------
    // expected pixels
    // ----------------------------------------

    task automatic make_frame();
        for (int k = 0; k < FRAME_PIX; k++) begin
            cam1_pix[k] = 16'($random(seed));
            cam2_pix[k] = 16'($random(seed));
        end
    endtask

    // the first camera byte is the high byte.
    function automatic logic [23:0] expect_rgb(view_sel_t v, logic [15:0] p1,
                                               logic [15:0] p2);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        case (v)
            VIEW_CAM2: begin
                r = p2[15:11];
                g = p2[10:5];
                b = p2[4:0];
            end
            VIEW_AVG: begin
                r = 5'((6'(p1[15:11]) + 6'(p2[15:11])) >> 1);  // floor of the mean.
                g = 6'((7'(p1[10:5]) + 7'(p2[10:5])) >> 1);
                b = 5'((6'(p1[4:0]) + 6'(p2[4:0])) >> 1);
            end
            default: begin
                r = p1[15:11];
                g = p1[10:5];
                b = p1[4:0];
            end
        endcase
        return {r, 3'b000, g, 2'b00, b, 3'b000};
    endfunction

`endif

// ==== testbench/aimbot_tb.sv ====
`timescale 1ns/1ps

`include "aimbot_defs.svh"

module aimbot_tb;

    import aimbot_pkg::*;

    localparam int CLK_NS    = 4;
    localparam int LINE      = `AIM_LINE_PIXELS;
    localparam int FRAME_PIX = 2 * LINE;
    localparam int FRAME_CYC = 1 + 2 * (2 * LINE + 1);  // vsync, two lines, line gaps.
    localparam int QUIET_CYC = 2 * LINE + `AIM_HSYNC_LEN;

    logic       clk;
    logic       arst_n;
    logic       cam1_href;
    logic       cam1_vsync;
    logic [7:0] cam1_data;
    logic       cam2_href;
    logic       cam2_vsync;
    logic [7:0] cam2_data;
    view_sel_t  view;
    logic       vid_ready;
    logic       de;
    logic       hsync;
    logic       vsync;
    logic [7:0] rgb_r;
    logic [7:0] rgb_g;
    logic [7:0] rgb_b;
    logic       tick;
    logic       overflow;
    logic       comb_err;

    int          seed = 48320;
    int          err_count = 0;
    int          cases_ok = 0;
    int          cases_bad = 0;
    int          cyc = 0;
    logic [7:0]  ready_mask = 8'hff;
    logic [23:0] exp_q [$];
    logic        exact_mode = 1'b1;
    int          next_idx = 0;
    int          beats_seen;  // monitor counters cleared by reset.
    int          lines_seen;
    int          hs_run;
    int          hs_pulses;
    int          ticks_seen;
    int          quiet;
    logic        hs_due;

    `include "aimbot_cases.svh"

    localparam int WATCHDOG_NS = NUM_CASES * 2 * FRAME_CYC * CLK_NS * 4 + 200 * CLK_NS;

    aimbot_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    // ----------------------------------------
    // reporting and stimulus
    // ----------------------------------------

    task automatic report_value(input string name, input logic [23:0] exp,
                                input logic [23:0] got);
        $display("** Error: %s expected %0h, got %0h", name, exp, got);
        err_count++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        err_count++;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        vid_ready = ready_mask[cyc % 8];
        cyc++;
    endtask

    task automatic drive(input logic h1, input logic v1, input logic [7:0] d1,
                         input logic h2, input logic v2, input logic [7:0] d2);
        step();
        cam1_href  = h1;
        cam1_vsync = v1;
        cam1_data  = d1;
        cam2_href  = h2;
        cam2_vsync = v2;
        cam2_data  = d2;
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (3) step();
        arst_n = 1'b1;
    endtask

    task automatic send_frame();
        logic [15:0] p1;
        logic [15:0] p2;
        drive(1'b0, 1'b1, 8'h00, 1'b0, 1'b1, 8'h00);
        for (int l = 0; l < 2; l++) begin
            for (int k = 0; k < LINE; k++) begin
                p1 = cam1_pix[l * LINE + k];
                p2 = cam2_pix[l * LINE + k];
                drive(1'b1, 1'b0, p1[15:8], 1'b1, 1'b0, p2[15:8]);
                drive(1'b1, 1'b0, p1[7:0], 1'b1, 1'b0, p2[7:0]);
            end
            drive(1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 8'h00);  // gap between lines.
        end
    endtask

    // ----------------------------------------
    // monitor
    // ----------------------------------------

    task automatic check_beat();
        int   idx;
        logic exp_vs;
        idx = next_idx;
        // dropped pixels leave gaps, so search forward.
        if (!exact_mode) begin
            while (idx < exp_q.size() && exp_q[idx] != {rgb_r, rgb_g, rgb_b}) begin
                idx++;
            end
        end
        beats_seen++;
        if (idx >= exp_q.size()) begin
            report_failure($sformatf("de beat %0d with rgb %h matches no sent pixel",
                                     beats_seen, {rgb_r, rgb_g, rgb_b}));
        end else begin
            exp_vs = (idx % FRAME_PIX == 0);
            if (rgb_r !== exp_q[idx][23:16]) begin
                report_value("rgb_r", 24'(exp_q[idx][23:16]), 24'(rgb_r));
            end
            if (rgb_g !== exp_q[idx][15:8]) begin
                report_value("rgb_g", 24'(exp_q[idx][15:8]), 24'(rgb_g));
            end
            if (rgb_b !== exp_q[idx][7:0]) begin
                report_value("rgb_b", 24'(exp_q[idx][7:0]), 24'(rgb_b));
            end
            if (vsync !== exp_vs) begin
                report_value("vsync", 24'(exp_vs), 24'(vsync));
            end
            if (idx % LINE == LINE - 1) begin
                lines_seen++;
                hs_due = 1'b1;
            end
            next_idx = idx + 1;
        end
    endtask

    always @(negedge clk) begin
        if (!arst_n) begin
            beats_seen = 0;
            lines_seen = 0;
            hs_run     = 0;
            hs_pulses  = 0;
            ticks_seen = 0;
            quiet      = 0;
            hs_due     = 1'b0;
        end else begin
            quiet = (de || hsync || !vid_ready) ? 0 : quiet + 1;
            if (de && hsync) begin
                report_failure("de and hsync are high in the same cycle");
            end
            if (hs_due && !hsync) begin
                report_failure("hsync did not start after the end of a line");
            end
            hs_due = 1'b0;
            if (hsync) begin
                hs_run++;
            end else if (hs_run != 0) begin
                if (hs_run != `AIM_HSYNC_LEN) begin
                    report_value("hsync length", 24'(`AIM_HSYNC_LEN), 24'(hs_run));
                end
                hs_pulses++;
                hs_run = 0;
            end
            if (tick) begin
                ticks_seen++;
            end
            if (de) begin
                check_beat();
            end
        end
    end

    // ----------------------------------------
    // cases
    // ----------------------------------------

    task automatic run_case(input int n);
        case_t c;
        int    errs_before;
        c = cases[n];
        errs_before = err_count;
        make_frame();
        exp_q.delete();
        for (int f = 0; f < int'(c.frames); f++) begin
            for (int k = 0; k < FRAME_PIX; k++) begin
                exp_q.push_back(expect_rgb(c.view, cam1_pix[k], cam2_pix[k]));
            end
        end
        exact_mode = !c.exp_ovf;
        next_idx   = 0;
        view       = c.view;
        ready_mask = c.ready_mask;
        apply_reset();
        if (c.misalign) begin
            drive(1'b0, 1'b0, 8'h00, 1'b1, 1'b0, 8'h3c);  // camera 2 only.
            drive(1'b0, 1'b0, 8'h00, 1'b1, 1'b0, 8'hc3);
        end
        for (int f = 0; f < int'(c.frames); f++) begin
            send_frame();
        end
        ready_mask = 8'hff;
        while (quiet < QUIET_CYC) begin
            step();
        end
        if (exact_mode && beats_seen != exp_q.size()) begin
            report_value("de beat count", 24'(exp_q.size()), 24'(beats_seen));
        end
        if (hs_pulses != lines_seen) begin
            report_value("hsync pulse count", 24'(lines_seen), 24'(hs_pulses));
        end
        if (ticks_seen != lines_seen / `AIM_TICK_LINES) begin
            report_value("tick count", 24'(lines_seen / `AIM_TICK_LINES), 24'(ticks_seen));
        end
        if (overflow !== c.exp_ovf) begin
            report_value("overflow", 24'(c.exp_ovf), 24'(overflow));
        end
        if (comb_err !== c.exp_err) begin
            report_value("comb_err", 24'(c.exp_err), 24'(comb_err));
        end
        if (err_count == errs_before) begin
            cases_ok++;
        end else begin
            cases_bad++;
        end
        $display("case %0d view %0d: %0d beats, %0d lines, %0d ticks, %s", n, c.view,
                 beats_seen, lines_seen, ticks_seen, (err_count == errs_before) ? "pass" : "fail");
    endtask

    initial begin
        arst_n     = 1'b0;
        cam1_href  = 1'b0;
        cam1_vsync = 1'b0;
        cam1_data  = 8'h00;
        cam2_href  = 1'b0;
        cam2_vsync = 1'b0;
        cam2_data  = 8'h00;
        view       = VIEW_CAM1;
        vid_ready  = 1'b1;
        apply_reset();
        repeat (2) step();
        if ({de, hsync, vsync, tick, overflow, comb_err} !== 6'b0) begin
            report_value("{de,hsync,vsync,tick,overflow,comb_err}", 24'h0,
                         24'({de, hsync, vsync, tick, overflow, comb_err}));
        end
        for (int n = 0; n < NUM_CASES; n++) begin
            run_case(n);
        end
        $display("%0d cases passed, %0d failed, %0d errors", cases_ok, cases_bad, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : aimbot_tb

// ==== source/aimbot_top.sv ====
`timescale 1ns/1ps

`include "aimbot_defs.svh"

module aimbot_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cam1_href,
    input  logic                  cam1_vsync,
    input  logic [7:0]            cam1_data,
    input  logic                  cam2_href,
    input  logic                  cam2_vsync,
    input  logic [7:0]            cam2_data,
    input  aimbot_pkg::view_sel_t view,
    input  logic                  vid_ready,
    output logic                  de,
    output logic                  hsync,
    output logic                  vsync,
    output logic [7:0]            rgb_r,
    output logic [7:0]            rgb_g,
    output logic [7:0]            rgb_b,
    output logic                  tick,
    output logic                  overflow,
    output logic                  comb_err
);

    import aimbot_pkg::*;

    cam_beat_t  cam1_beat;
    cam_beat_t  cam2_beat;
    logic       cam1_valid;
    logic       cam2_valid;
    logic       cam1_ready;
    logic       cam2_ready;
    logic       cam1_ovf;
    logic       cam2_ovf;
    cam_beat_t  fifo1_beat;
    cam_beat_t  fifo2_beat;
    logic       fifo1_valid;
    logic       fifo2_valid;
    logic       fifo1_ready;
    logic       fifo2_ready;
    pair_beat_t pair_beat;
    logic       pair_valid;
    logic       pair_ready;
    logic       line_done;

    assign overflow = cam1_ovf | cam2_ovf;

    // ----------------------------------------
    // camera 1 path
    // ----------------------------------------

    cam_byte_packer u_cam1_packer (
        .clk(clk), .arst_n(arst_n),
        .href(cam1_href), .vsync(cam1_vsync), .data(cam1_data),
        .beat(cam1_beat), .valid(cam1_valid), .ready(cam1_ready),
        .overflow(cam1_ovf)
    );

    pixel_fifo #(.DEPTH(`AIM_FIFO_DEPTH)) u_cam1_fifo (
        .clk(clk), .arst_n(arst_n),
        .in_beat(cam1_beat), .in_valid(cam1_valid), .in_ready(cam1_ready),
        .out_beat(fifo1_beat), .out_valid(fifo1_valid), .out_ready(fifo1_ready)
    );

    // ----------------------------------------
    // camera 2 path
    // ----------------------------------------

    cam_byte_packer u_cam2_packer (
        .clk(clk), .arst_n(arst_n),
        .href(cam2_href), .vsync(cam2_vsync), .data(cam2_data),
        .beat(cam2_beat), .valid(cam2_valid), .ready(cam2_ready),
        .overflow(cam2_ovf)
    );

    pixel_fifo #(.DEPTH(`AIM_FIFO_DEPTH)) u_cam2_fifo (
        .clk(clk), .arst_n(arst_n),
        .in_beat(cam2_beat), .in_valid(cam2_valid), .in_ready(cam2_ready),
        .out_beat(fifo2_beat), .out_valid(fifo2_valid), .out_ready(fifo2_ready)
    );

    // ----------------------------------------
    // pairing, view and line tick
    // ----------------------------------------

    pixel_combine u_pixel_combine (
        .clk(clk), .arst_n(arst_n),
        .a_beat(fifo1_beat), .a_valid(fifo1_valid), .a_ready(fifo1_ready),
        .b_beat(fifo2_beat), .b_valid(fifo2_valid), .b_ready(fifo2_ready),
        .pair(pair_beat), .pair_valid(pair_valid), .pair_ready(pair_ready),
        .err(comb_err)
    );

    video_out u_video_out (
        .clk(clk), .arst_n(arst_n),
        .pair(pair_beat), .pair_valid(pair_valid), .pair_ready(pair_ready),
        .vid_ready(vid_ready), .view(view),
        .de(de), .hsync(hsync), .vsync(vsync),
        .rgb_r(rgb_r), .rgb_g(rgb_g), .rgb_b(rgb_b),
        .line_done(line_done)
    );

    line_tick #(.TICK_LINES(`AIM_TICK_LINES)) u_line_tick (
        .clk(clk), .arst_n(arst_n),
        .line_done(line_done), .tick(tick)
    );

endmodule : aimbot_top

// ==== source/line_tick.sv ====
`timescale 1ns/1ps

`include "aimbot_defs.svh"

module line_tick #(
    parameter int TICK_LINES = `AIM_TICK_LINES
) (
    input  logic clk,
    input  logic arst_n,
    input  logic line_done,
    output logic tick
);

    localparam int CNT_W = $clog2(TICK_LINES + 1);

    logic [CNT_W-1:0] line_cnt;
    logic             wrap;

    assign wrap = (line_cnt == CNT_W'(TICK_LINES - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (line_done) begin
                if (wrap) begin
                    line_cnt <= '0;
                    tick     <= 1'b1;  // one pulse per period.
                end else begin
                    line_cnt <= line_cnt + 1'b1;
                end
            end
        end
    end

endmodule : line_tick

// ==== source/video_out.sv ====
`timescale 1ns/1ps

`include "aimbot_defs.svh"

module video_out (
    input  logic                   clk,
    input  logic                   arst_n,
    input  aimbot_pkg::pair_beat_t pair,
    input  logic                   pair_valid,
    output logic                   pair_ready,
    input  logic                   vid_ready,
    input  aimbot_pkg::view_sel_t  view,
    output logic                   de,
    output logic                   hsync,
    output logic                   vsync,
    output logic [7:0]             rgb_r,
    output logic [7:0]             rgb_g,
    output logic [7:0]             rgb_b,
    output logic                   line_done
);

    import aimbot_pkg::*;

    localparam int HS_LEN = `AIM_HSYNC_LEN;
    localparam int HS_W   = $clog2(HS_LEN + 1);

    pix565_t         p1;
    pix565_t         p2;
    pix565_t         sel;
    logic [5:0]      sum_r;
    logic [6:0]      sum_g;
    logic [5:0]      sum_b;
    logic            accept;
    logic            line_end_q;  // de cycle of an eol beat.
    logic [HS_W-1:0] hs_cnt;

    // ----------------------------------------
    // view select
    // ----------------------------------------

    assign p1    = pair.pix1.color;
    assign p2    = pair.pix2.color;
    assign sum_r = {1'b0, p1.red} + {1'b0, p2.red};
    assign sum_g = {1'b0, p1.green} + {1'b0, p2.green};
    assign sum_b = {1'b0, p1.blue} + {1'b0, p2.blue};

    always_comb begin
        case (view)
            VIEW_CAM2: sel = p2;
            VIEW_AVG: begin
                sel.red   = sum_r[5:1];  // floor of the mean.
                sel.green = sum_g[6:1];
                sel.blue  = sum_b[5:1];
            end
            default:   sel = p1;
        endcase
    end

    // ----------------------------------------
    // handshake and sync
    // ----------------------------------------

    assign pair_ready = vid_ready && !hsync && !line_end_q;
    assign accept     = pair_valid && pair_ready;
    assign line_done  = accept && pair.eol;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de         <= 1'b0;
            vsync      <= 1'b0;
            line_end_q <= 1'b0;
            hsync      <= 1'b0;
            hs_cnt     <= '0;
        end else begin
            de         <= accept;
            vsync      <= accept && pair.sof;
            line_end_q <= line_done;
            if (line_end_q) begin
                hsync  <= 1'b1;
                hs_cnt <= HS_W'(HS_LEN - 1);
            end else if (hsync) begin
                if (hs_cnt == '0) begin
                    hsync <= 1'b0;
                end else begin
                    hs_cnt <= hs_cnt - 1'b1;
                end
            end
        end
    end

    // widen to 8 bits per channel.
    always_ff @(posedge clk) begin
        if (accept) begin
            rgb_r <= {sel.red, 3'b000};
            rgb_g <= {sel.green, 2'b00};
            rgb_b <= {sel.blue, 3'b000};
        end
    end

    a_de_hsync : assert property (@(posedge clk) disable iff (!arst_n)
        !(de && hsync));

endmodule : video_out

// ==== source/pixel_combine.sv ====
`timescale 1ns/1ps

module pixel_combine (
    input  logic                   clk,
    input  logic                   arst_n,
    input  aimbot_pkg::cam_beat_t  a_beat,
    input  logic                   a_valid,
    output logic                   a_ready,
    input  aimbot_pkg::cam_beat_t  b_beat,
    input  logic                   b_valid,
    output logic                   b_ready,
    output aimbot_pkg::pair_beat_t pair,
    output logic                   pair_valid,
    input  logic                   pair_ready,
    output logic                   err
);

    logic out_free;
    logic pop;
    logic flag_diff;

    // ----------------------------------------
    // lockstep pop
    // ----------------------------------------

    assign out_free  = !pair_valid || pair_ready;
    assign pop       = a_valid && b_valid && out_free;
    assign a_ready   = pop;
    assign b_ready   = pop;
    assign flag_diff = (a_beat.sof != b_beat.sof) || (a_beat.eol != b_beat.eol);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pair_valid <= 1'b0;
        end else if (pop) begin
            pair_valid <= 1'b1;
        end else if (pair_ready) begin
            pair_valid <= 1'b0;
        end
    end

    // camera 1 owns the frame flags.
    always_ff @(posedge clk) begin
        if (pop) begin
            pair.sof  <= a_beat.sof;
            pair.eol  <= a_beat.eol;
            pair.pix1 <= a_beat.pix;
            pair.pix2 <= b_beat.pix;
        end
    end

    // ----------------------------------------
    // alignment check
    // ----------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err <= 1'b0;
        end else if (pop && flag_diff) begin
            err <= 1'b1;
        end
    end

    // both FIFOs drain together and the pair shows up next cycle.
    a_lockstep : assert property (@(posedge clk) disable iff (!arst_n)
        (a_ready || b_ready) |-> (a_ready && b_ready) ##1 pair_valid);

endmodule : pixel_combine

// ==== source/pixel_fifo.sv ====
`timescale 1ns/1ps

`include "aimbot_defs.svh"

module pixel_fifo #(
    parameter int DEPTH = `AIM_FIFO_DEPTH
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  aimbot_pkg::cam_beat_t in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,
    output aimbot_pkg::cam_beat_t out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    import aimbot_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    cam_beat_t     mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign in_ready  = (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // no write lands while the buffer is full.
    a_no_push_full : assert property (@(posedge clk) disable iff (!arst_n)
        (count == CW'(DEPTH)) |=> (wr_ptr == $past(wr_ptr)));

    a_out_hold : assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)));

endmodule : pixel_fifo

// ==== source/cam_byte_packer.sv ====
`timescale 1ns/1ps

`include "aimbot_defs.svh"

module cam_byte_packer (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  href,
    input  logic                  vsync,
    input  logic [7:0]            data,
    output aimbot_pkg::cam_beat_t beat,
    output logic                  valid,
    input  logic                  ready,
    output logic                  overflow
);

    localparam int LINE  = `AIM_LINE_PIXELS;
    localparam int CNT_W = (LINE > 1) ? $clog2(LINE) : 1;

    logic             phase;      // high once the hi byte is held.
    logic [7:0]       hi_q;
    logic [CNT_W-1:0] pix_cnt;
    logic             sof_armed;
    logic             last_pix;

    assign last_pix = (pix_cnt == CNT_W'(LINE - 1));

    // ----------------------------------------
    // byte pairing and frame tags
    // ----------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase     <= 1'b0;
            pix_cnt   <= '0;
            sof_armed <= 1'b0;
            valid     <= 1'b0;
        end else begin
            valid <= 1'b0;  // one-cycle strobe.
            if (vsync) begin
                phase     <= 1'b0;
                pix_cnt   <= '0;
                sof_armed <= 1'b1;
            end else if (href) begin
                phase <= ~phase;
                if (phase) begin
                    valid     <= 1'b1;
                    sof_armed <= 1'b0;
                    pix_cnt   <= last_pix ? '0 : pix_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!phase && href && !vsync) begin
            hi_q <= data;
        end
        if (phase && href && !vsync) begin
            beat.sof          <= sof_armed;
            beat.eol          <= last_pix;
            beat.pix.bytes.hi <= hi_q;
            beat.pix.bytes.lo <= data;
        end
    end

    // a beat that meets a full FIFO is lost.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            overflow <= 1'b0;
        end else if (valid && !ready) begin
            overflow <= 1'b1;
        end
    end

    // two bytes per pixel, so beats never come back to back.
    a_valid_gap : assert property (@(posedge clk) disable iff (!arst_n)
        valid |=> !valid);

endmodule : cam_byte_packer

// ==== source/aimbot_pkg.sv ====
package aimbot_pkg;

    // ----------------------------------------
    // pixel encodings
    // ----------------------------------------

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pix565_t;

    typedef struct packed {
        logic [7:0] hi;  // first camera byte.
        logic [7:0] lo;  // second camera byte.
    } pix_byte_t;

    // the packer fills bytes, the view stage reads color.
    typedef union packed {
        pix_byte_t bytes;
        pix565_t   color;
    } pix_word_u;

    // ----------------------------------------
    // stream beats
    // ----------------------------------------

    typedef struct packed {
        logic      sof;  // first pixel of a frame.
        logic      eol;  // last pixel of a line.
        pix_word_u pix;
    } cam_beat_t;

    typedef struct packed {
        logic      sof;
        logic      eol;
        pix_word_u pix1;
        pix_word_u pix2;
    } pair_beat_t;

    typedef enum logic [1:0] {
        VIEW_CAM1 = 2'd0,
        VIEW_CAM2 = 2'd1,
        VIEW_AVG  = 2'd2
    } view_sel_t;

endpackage : aimbot_pkg

// ==== source/aimbot_defs.svh ====
`ifndef AIMBOT_DEFS_SVH
`define AIMBOT_DEFS_SVH

// ----------------------------------------
// video geometry
// ----------------------------------------

// pixels per line, small for simulation.
`define AIM_LINE_PIXELS 8

// hsync pulse length in clk cycles.
`define AIM_HSYNC_LEN 3

// ----------------------------------------
// buffering and housekeeping
// ----------------------------------------

// depth of each camera FIFO.
`define AIM_FIFO_DEPTH 16

// lines per tick pulse.
`define AIM_TICK_LINES 4

`endif
